// ==== hw/inq_pkg.sv ====
/*
 * Shared sizes, request opcodes and bus structs for the inbound packet queue.
 * Every RTL block pulls these in with a wildcard import in its module header.
 */

`default_nettype none

package inq_pkg;

   ////////////////////////////////////////
   // sizes
   ////////////////////////////////////////

   localparam int unsigned inq_entries = 32;
   localparam int unsigned inq_adr_w   = 5;
   localparam int unsigned inq_data_w  = 108;
   localparam int unsigned inq_lanes   = 4;
   // one bit wider than the address so a full queue fits
   localparam int unsigned inq_cnt_w   = 6;

   ////////////////////////////////////////
   // opcodes
   ////////////////////////////////////////

   typedef enum logic [1:0] {
      wr_idle  = 2'd0,
      wr_merge = 2'd1,
      wr_push  = 2'd2
   } wr_op_e;

   // dequeue is the stronger of the two reads
   typedef enum logic [1:0] {
      rd_idle = 2'd0,
      rd_deq  = 2'd1,
      rd_peek = 2'd2
   } rd_op_e;

   ////////////////////////////////////////
   // request and response buses
   ////////////////////////////////////////

   typedef struct packed {
      wr_op_e                  op;
      logic [inq_lanes-1:0]    lanes;
      logic [inq_data_w-1:0]   data;
   } wr_req_t;

   typedef struct packed {
      rd_op_e                  op;
      logic [inq_adr_w-1:0]    offset;
   } rd_req_t;

   // register file write port, lanes are bit i mod 4
   typedef struct packed {
      logic                    en;
      logic [inq_adr_w-1:0]    adr;
      logic [inq_lanes-1:0]    lanes;
      logic [inq_data_w-1:0]   data;
   } rf_wr_t;

   typedef struct packed {
      logic                    valid;
      logic [inq_data_w-1:0]   data;
   } rd_resp_t;

endpackage

`default_nettype wire

// ==== hw/inq_rf.sv ====
/*
 * 32 x 108 register file with one read and one write port.
 * Inputs are captured into d1 flops; the array write lands one edge later,
 * merged lane by lane, where lane n owns every bit i with i mod 4 == n.
 */

`timescale 1ns/1ns
`default_nettype none

module inq_rf
   import inq_pkg::*;
(
   input  wire logic                  rclk,
   input  wire logic                  reset_l,
   input  wire rf_wr_t                rf_wr,
   input  wire logic                  rd_en,
   input  wire logic [inq_adr_w-1:0]  rd_adr_head,
   input  wire logic [inq_adr_w-1:0]  rd_adr_peek,
   input  wire logic                  sel_head,
   output logic [inq_data_w-1:0]      rf_dout
);

   // captured write request
   logic                   wr_en_d1;
   logic [inq_adr_w-1:0]   wr_adr_d1;
   logic [inq_lanes-1:0]   wr_lanes_d1;
   logic [inq_data_w-1:0]  wr_data_d1;

   // captured read request
   logic                   ren_d1;
   logic [inq_adr_w-1:0]   rdptr_d1;

   // per-bit write enable built from the lane enables
   logic [inq_data_w-1:0]  bit_en;

   // storage
   logic [inq_data_w-1:0]  inq_ary [inq_entries];

   ////////////////////////////////////////
   // input capture
   ////////////////////////////////////////

   // enables are cleared by reset
   always_ff @(posedge rclk) begin
      if (reset_l) begin
         wr_en_d1 <= 1'b0;
         ren_d1   <= 1'b0;
      end else begin
         wr_en_d1 <= rf_wr.en;
         ren_d1   <= rd_en;
      end
   end

   // addresses and data just follow the inputs
   always_ff @(posedge rclk) begin
      wr_adr_d1   <= rf_wr.adr;
      wr_lanes_d1 <= rf_wr.lanes;
      wr_data_d1  <= rf_wr.data;
      // head address for a dequeue, offset address for a peek
      rdptr_d1    <= sel_head ? rd_adr_head : rd_adr_peek;
   end

   ////////////////////////////////////////
   // lane expansion
   ////////////////////////////////////////

   // interleaved lanes, so bit 0,4,8.. follow lane 0 and so on
   always_comb begin
      for (int i = 0; i < inq_data_w; i++) begin
         bit_en[i] = wr_lanes_d1[i % inq_lanes];
      end
   end

   ////////////////////////////////////////
   // write
   ////////////////////////////////////////

   // bits outside the enabled lanes keep their old value
   always_ff @(posedge rclk) begin
      if (!reset_l && wr_en_d1) begin
         inq_ary[wr_adr_d1] <= (inq_ary[wr_adr_d1] & ~bit_en) |
                               (wr_data_d1 & bit_en);
      end
   end

   ////////////////////////////////////////
   // read
   ////////////////////////////////////////

   // the array still holds the old entry here, so a read that was
   // captured together with a write to the same entry sees old data
   always_comb begin
      if (reset_l) begin
         rf_dout = '0;
      end else if (ren_d1) begin
         rf_dout = inq_ary[rdptr_d1];
      end else begin
         rf_dout = '0;
      end
   end

endmodule

`default_nettype wire

// ==== hw/inq_wr_ctl.sv ====
/*
 * Write side of the queue. Decodes merge and push against full,
 * owns the tail pointer, and flags writes that arrive while full.
 */

`timescale 1ns/1ns
`default_nettype none

module inq_wr_ctl
   import inq_pkg::*;
(
   input  wire logic     rclk,
   input  wire logic     reset_l,
   input  wire wr_req_t  wr_req,
   input  wire logic     full,
   output rf_wr_t        rf_wr,
   output logic          push_done,
   output logic          overflow
);

   // entry currently being built by merges
   logic [inq_adr_w-1:0] tail;

   // merge or push present on the bus
   logic                 wr_op_act;
   logic                 wr_acc;

   ////////////////////////////////////////
   // decode
   ////////////////////////////////////////

   assign wr_op_act = (wr_req.op == wr_merge) || (wr_req.op == wr_push);

   // nothing is written once the queue is full
   assign wr_acc    = wr_op_act && !full;

   // a push closes the tail entry and hands it to the read side
   assign push_done = wr_acc && (wr_req.op == wr_push);

   ////////////////////////////////////////
   // register file write
   ////////////////////////////////////////

   // merge and push both write the tail entry with the given lanes,
   // the push write is the last one that entry gets
   always_comb begin
      rf_wr.en    = wr_acc;
      rf_wr.adr   = tail;
      rf_wr.lanes = wr_req.lanes;
      rf_wr.data  = wr_req.data;
   end

   ////////////////////////////////////////
   // tail pointer and overflow
   ////////////////////////////////////////

   // wraps at 32 through the 5 bit width
   always_ff @(posedge rclk) begin
      if (reset_l) begin
         tail <= '0;
      end else if (push_done) begin
         tail <= tail + 1'b1;
      end
   end

   // sticky until the next reset
   always_ff @(posedge rclk) begin
      if (reset_l) begin
         overflow <= 1'b0;
      end else if (wr_op_act && full) begin
         overflow <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== hw/inq_rd_ctl.sv ====
/*
 * Read side of the queue. Holds the head pointer and occupancy count,
 * checks dequeue and peek requests, steers the register file read
 * address and registers the read response one edge after the array read.
 */

`timescale 1ns/1ns
`default_nettype none

module inq_rd_ctl
   import inq_pkg::*;
(
   input  wire logic                   rclk,
   input  wire logic                   reset_l,
   input  wire rd_req_t                rd_req,
   input  wire logic                   push_done,
   input  wire logic [inq_data_w-1:0]  rf_dout,
   output logic                        full,
   output logic                        empty,
   output logic [inq_cnt_w-1:0]        count,
   output logic                        rd_en,
   output logic [inq_adr_w-1:0]        rd_adr_head,
   output logic [inq_adr_w-1:0]        rd_adr_peek,
   output logic                        sel_head,
   output rd_resp_t                    rd_resp
);

   logic [inq_adr_w-1:0]  head;
   logic                  deq_acc;
   logic                  peek_acc;

   // read in the register file capture stage
   logic                  rd_vld_d1;

   // response flops
   logic                  resp_vld;
   logic [inq_data_w-1:0] resp_data;

   ////////////////////////////////////////
   // status
   ////////////////////////////////////////

   assign empty = (count == '0);
   assign full  = (count == inq_cnt_w'(inq_entries));

   ////////////////////////////////////////
   // request decode
   ////////////////////////////////////////

   assign deq_acc  = (rd_req.op == rd_deq) && !empty;
   // offset must point at a pushed entry
   assign peek_acc = (rd_req.op == rd_peek) && ({1'b0, rd_req.offset} < count);

   assign rd_en       = deq_acc || peek_acc;
   assign sel_head    = (rd_req.op == rd_deq);
   assign rd_adr_head = head;
   // wraps mod 32 through the address width
   assign rd_adr_peek = head + rd_req.offset;

   ////////////////////////////////////////
   // head pointer and count
   ////////////////////////////////////////

   always_ff @(posedge rclk) begin
      if (reset_l) begin
         head <= '0;
      end else if (deq_acc) begin
         head <= head + 1'b1;
      end
   end

   // push and dequeue together leave the count where it was
   always_ff @(posedge rclk) begin
      if (reset_l) begin
         count <= '0;
      end else begin
         case ({push_done, deq_acc})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   ////////////////////////////////////////
   // response
   ////////////////////////////////////////

   // valid follows the read through the capture stage of the array
   always_ff @(posedge rclk) begin
      if (reset_l) begin
         rd_vld_d1 <= 1'b0;
         resp_vld  <= 1'b0;
      end else begin
         rd_vld_d1 <= rd_en;
         resp_vld  <= rd_vld_d1;
      end
   end

   always_ff @(posedge rclk) begin
      resp_data <= rf_dout;
   end

   assign rd_resp.valid = resp_vld;
   assign rd_resp.data  = resp_data;

endmodule

`default_nettype wire

// ==== hw/inq_top.sv ====
/*
 * Inbound packet queue top level. Write control builds and pushes
 * tail entries, read control dequeues and peeks, both around one
 * 32 x 108 register file.
 */

`timescale 1ns/1ns
`default_nettype none

module inq_top
   import inq_pkg::*;
(
   input  wire logic              rclk,
   input  wire logic              reset_l,
   input  wire wr_req_t           wr_req,
   input  wire rd_req_t           rd_req,
   output rd_resp_t               rd_resp,
   output logic [inq_cnt_w-1:0]   count,
   output logic                   empty,
   output logic                   full,
   output logic                   overflow
);

   // write side to register file
   rf_wr_t                 rf_wr;
   logic                   push_done;

   // read side to register file
   logic                   rd_en;
   logic [inq_adr_w-1:0]   rd_adr_head;
   logic [inq_adr_w-1:0]   rd_adr_peek;
   logic                   sel_head;
   logic [inq_data_w-1:0]  rf_dout;

   inq_wr_ctl i_wr_ctl (
      .rclk      (rclk),
      .reset_l   (reset_l),
      .wr_req    (wr_req),
      .full      (full),
      .rf_wr     (rf_wr),
      .push_done (push_done),
      .overflow  (overflow)
   );

   inq_rd_ctl i_rd_ctl (
      .rclk        (rclk),
      .reset_l     (reset_l),
      .rd_req      (rd_req),
      .push_done   (push_done),
      .rf_dout     (rf_dout),
      .full        (full),
      .empty       (empty),
      .count       (count),
      .rd_en       (rd_en),
      .rd_adr_head (rd_adr_head),
      .rd_adr_peek (rd_adr_peek),
      .sel_head    (sel_head),
      .rd_resp     (rd_resp)
   );

   inq_rf i_rf (
      .rclk        (rclk),
      .reset_l     (reset_l),
      .rf_wr       (rf_wr),
      .rd_en       (rd_en),
      .rd_adr_head (rd_adr_head),
      .rd_adr_peek (rd_adr_peek),
      .sel_head    (sel_head),
      .rf_dout     (rf_dout)
   );

endmodule

`default_nettype wire

// ==== tests/inq_sva.sv ====
/*
 * Port level assertions for the inbound packet queue,
 * attached to every inq_top instance through the bind below.
 */

`timescale 1ns/1ns
`default_nettype none

module inq_sva
   import inq_pkg::*;
(
   input  wire logic                  rclk,
   input  wire logic                  reset_l,
   input  wire rd_resp_t              rd_resp,
   input  wire logic [inq_cnt_w-1:0]  count,
   input  wire logic                  empty,
   input  wire logic                  full,
   input  wire logic                  overflow
);

   // number of assertion failures so far
   int unsigned fail_cnt = 0;

   // status flags are exclusive
   a_full_empty: assert property (@(posedge rclk) disable iff (reset_l)
      !(full && empty))
      else begin
         $error("full and empty are both set");
         fail_cnt++;
      end

   a_count_max: assert property (@(posedge rclk) disable iff (reset_l)
      count <= inq_cnt_w'(inq_entries))
      else begin
         $error("count is above the number of entries");
         fail_cnt++;
      end

   // response flop is cleared by reset
   a_no_valid_in_reset: assert property (@(posedge rclk)
      reset_l |=> !rd_resp.valid)
      else begin
         $error("rd_resp.valid set after a reset cycle");
         fail_cnt++;
      end

   // sticky until the next reset
   a_overflow_sticky: assert property (@(posedge rclk) disable iff (reset_l)
      overflow |=> overflow)
      else begin
         $error("overflow dropped without reset");
         fail_cnt++;
      end

endmodule

bind inq_top inq_sva i_sva (
   .rclk     (rclk),
   .reset_l  (reset_l),
   .rd_resp  (rd_resp),
   .count    (count),
   .empty    (empty),
   .full     (full),
   .overflow (overflow)
);

`default_nettype wire

// ==== tests/inq_tb.sv ====
/*
 * Testbench for the inbound packet queue. Requests are driven on the falling
 * edge; a queue model follows every sampled request on the rising edge and
 * checks the read responses and the status outputs against it.
 */

`timescale 1ns/1ns
`default_nettype none

module inq_tb
   import inq_pkg::*;
();

   // one outstanding read response and the edge it is due at
   typedef struct packed {
      logic [31:0]           due;
      logic [inq_data_w-1:0] data;
   } exp_t;

   logic                  rclk;
   logic                  reset_l;
   wr_req_t               wr_req;
   rd_req_t               rd_req;
   rd_resp_t              rd_resp;
   logic [inq_cnt_w-1:0]  count;
   logic                  empty;
   logic                  full;
   logic                  overflow;
   integer                seed;

   // the model array keeps its contents over reset like the DUT
   logic [inq_data_w-1:0] m_ary [inq_entries];
   logic [inq_adr_w-1:0]  m_head;
   logic [inq_adr_w-1:0]  m_tail;
   int                    m_count;
   logic                  m_ovf;
   exp_t                  exp_q [$];
   int                    cyc = 0;
   bit                    started = 1'b0;

   inq_top i_dut (
      .rclk     (rclk),
      .reset_l  (reset_l),
      .wr_req   (wr_req),
      .rd_req   (rd_req),
      .rd_resp  (rd_resp),
      .count    (count),
      .empty    (empty),
      .full     (full),
      .overflow (overflow)
   );

   initial begin
      rclk = 1'b0;
      forever #10 rclk = ~rclk;
   end

   ////////////////////////////////////////
   // helpers
   ////////////////////////////////////////

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("ERRORS FOUND");
      $fatal(1, "simulation stopped after the first error");
   endtask

   task automatic mismatch(input string what);
      abort_run($sformatf("[FAIL] %0t ns: %s", $time, what));
   endtask

   // bit i takes the new value when lane i mod 4 is enabled
   function automatic logic [inq_data_w-1:0] merge_lanes(
      input logic [inq_data_w-1:0] old_val,
      input logic [inq_data_w-1:0] new_val,
      input logic [inq_lanes-1:0]  lanes
   );
      logic [inq_data_w-1:0] res;
      res = old_val;
      for (int i = 0; i < inq_data_w; i++) begin
         if (lanes[i % inq_lanes]) begin
            res[i] = new_val[i];
         end
      end
      return res;
   endfunction

   function automatic logic [inq_data_w-1:0] rand_data();
      logic [127:0] r;
      r = {$random(seed), $random(seed), $random(seed), $random(seed)};
      return r[inq_data_w-1:0];
   endfunction

   task automatic drive(input wr_op_e wop, input logic [inq_lanes-1:0] lanes,
                        input logic [inq_data_w-1:0] data, input rd_op_e rop,
                        input logic [inq_adr_w-1:0] offset);
      @(negedge rclk);
      wr_req.op     = wop;
      wr_req.lanes  = lanes;
      wr_req.data   = data;
      rd_req.op     = rop;
      rd_req.offset = offset;
   endtask

   task automatic idle(input int n);
      repeat (n) drive(wr_idle, '0, '0, rd_idle, '0);
   endtask

   task automatic wait_drain(input int limit);
      int n;
      n = 0;
      while (exp_q.size() != 0) begin
         if (n == limit) abort_run("timed out waiting for read responses");
         @(negedge rclk);
         n++;
      end
   endtask

   task automatic wait_full(input int limit);
      int n;
      n = 0;
      while (full !== 1'b1) begin
         if (n == limit) abort_run("timed out waiting for the queue to report full");
         @(negedge rclk);
         n++;
      end
   endtask

   ////////////////////////////////////////
   // compare and model update
   ////////////////////////////////////////

   // outputs seen here are the ones registered at the previous edge
   task automatic check_outputs();
      exp_t e;
      if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
         e = exp_q.pop_front();
         assert (rd_resp.valid === 1'b1)
            else mismatch("rd_resp.valid low where a read response was due");
         assert (rd_resp.data === e.data)
            else mismatch($sformatf("rd_resp.data %h, expected %h", rd_resp.data, e.data));
      end else begin
         assert (rd_resp.valid === 1'b0)
            else mismatch("rd_resp.valid high with no read due");
      end
      assert (count === inq_cnt_w'(m_count))
         else mismatch($sformatf("count %0d, expected %0d", count, m_count));
      assert (empty === (m_count == 0))
         else mismatch($sformatf("empty %b with %0d entries", empty, m_count));
      assert (full === (m_count == inq_entries))
         else mismatch($sformatf("full %b with %0d entries", full, m_count));
      assert (overflow === m_ovf)
         else mismatch($sformatf("overflow %b, expected %b", overflow, m_ovf));
   endtask

   always @(posedge rclk) begin : model_step
      exp_t                 e;
      logic                 wr_any;
      logic                 wr_ok;
      logic                 push_ok;
      logic                 deq_ok;
      logic                 peek_ok;
      logic [inq_adr_w-1:0] rd_adr;
      if (started) begin
         check_outputs();
      end
      if (reset_l) begin
         m_head  = '0;
         m_tail  = '0;
         m_count = 0;
         m_ovf   = 1'b0;
         exp_q.delete();
         started = 1'b1;
      end else begin
         wr_any  = (wr_req.op == wr_merge) || (wr_req.op == wr_push);
         wr_ok   = wr_any && (m_count != inq_entries);
         push_ok = wr_ok && (wr_req.op == wr_push);
         deq_ok  = (rd_req.op == rd_deq) && (m_count != 0);
         peek_ok = (rd_req.op == rd_peek) && (rd_req.offset < m_count);
         // reads come before this edge's write
         if (deq_ok || peek_ok) begin
            rd_adr = deq_ok ? m_head : m_head + rd_req.offset;
            e.due  = cyc + 2;
            e.data = m_ary[rd_adr];
            exp_q.push_back(e);
         end
         if (wr_any && !wr_ok) m_ovf = 1'b1;
         if (wr_ok) m_ary[m_tail] = merge_lanes(m_ary[m_tail], wr_req.data, wr_req.lanes);
         if (push_ok) m_tail = m_tail + 1'b1;
         if (deq_ok) m_head = m_head + 1'b1;
         m_count = m_count + int'(push_ok) - int'(deq_ok);
      end
      cyc++;
   end

   ////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////

   initial begin : stim
      logic [31:0] r;
      seed    = 32'h23c3;
      reset_l = 1'b1;
      wr_req  = '0;
      rd_req  = '0;
      repeat (4) @(negedge rclk);
      reset_l = 1'b0;
      idle(3);
      assert (count === '0 && empty === 1'b1 && full === 1'b0 && overflow === 1'b0)
         else mismatch("status outputs not at their reset values");

      // entries built from several merges, then dequeued in order
      for (int k = 0; k < 4; k++) begin
         drive(wr_merge, 4'b0011, rand_data(), rd_idle, '0);
         drive(wr_merge, 4'b0100, rand_data(), rd_idle, '0);
         drive(wr_merge, 4'b0001, rand_data(), rd_idle, '0);
         drive(wr_push,  4'b1000, rand_data(), rd_idle, '0);
      end
      repeat (4) drive(wr_idle, '0, '0, rd_deq, '0);
      idle(1);
      wait_drain(8);

      // peeks in range, out of range, then dequeue past empty
      repeat (5) drive(wr_push, 4'hf, rand_data(), rd_idle, '0);
      for (int k = 0; k < 5; k++) begin
         drive(wr_idle, '0, '0, rd_peek, inq_adr_w'(k));
      end
      drive(wr_idle, '0, '0, rd_peek, 5'd5);
      drive(wr_idle, '0, '0, rd_peek, 5'd31);
      repeat (6) drive(wr_idle, '0, '0, rd_deq, '0);
      idle(1);
      wait_drain(8);

      // fill, overflow, then wrap head and tail
      for (int k = 0; k < inq_entries; k++) begin
         drive(wr_push, 4'hf, rand_data(), rd_idle, '0);
      end
      wait_full(4);
      drive(wr_merge, 4'hf, rand_data(), rd_idle, '0);
      drive(wr_push, 4'hf, rand_data(), rd_idle, '0);
      drive(wr_idle, '0, '0, rd_deq, '0);
      drive(wr_push, 4'hf, rand_data(), rd_idle, '0);
      repeat (inq_entries + 1) drive(wr_idle, '0, '0, rd_deq, '0);
      idle(1);
      wait_drain(8);

      // mixed random traffic
      for (int k = 0; k < 2000; k++) begin
         r = $random(seed);
         drive((r[1:0] == 2'd3) ? wr_push : wr_op_e'(r[1:0]), r[5:2], rand_data(),
               (r[7:6] == 2'd3) ? rd_deq : rd_op_e'(r[7:6]), r[12:8]);
      end
      idle(2);
      wait_drain(8);

      if (i_dut.i_sva.fail_cnt != 0) begin
         abort_run("concurrent assertions on the DUT ports failed");
      end else begin
         $display("NO ERRORS");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== project.f ====
hw/inq_pkg.sv
hw/inq_rf.sv
hw/inq_wr_ctl.sv
hw/inq_rd_ctl.sv
hw/inq_top.sv
tests/inq_sva.sv
tests/inq_tb.sv
